/* common/csi_rx_pkg.sv */
// structs and enums shared by the csi-2 receiver blocks and the testbench
package csi_rx_pkg;

   // one lane after bit alignment
   typedef struct packed {
      logic [7:0] data;
      logic       valid;   // high from the byte after the sync byte
   } lane_byte_t;

   // deskewed two-lane word, also used for payload out
   typedef struct packed {
      logic [15:0] data;
      logic        valid;
   } word_t;

   // decoded packet header
   typedef struct packed {
      logic [1:0]  virtual_channel;
      logic [5:0]  data_type;
      logic [15:0] word_count;   // payload bytes for long packets, data field for short ones
   } header_t;

   // data type codes used on the link
   typedef enum logic [5:0] {
      frame_start = 6'h00,
      frame_end   = 6'h01,
      line_start  = 6'h02,
      line_end    = 6'h03,
      raw8        = 6'h2A
   } data_type_e;

   // packet handler fsm
   typedef enum logic [1:0] {
      idle,        // waiting for header word 0, sync requested
      header_hi,   // waiting for header word 1
      payload,     // forwarding payload words
      checksum     // dropping the crc word
   } packet_state_e;

endpackage

/* common/csi_rx_settings.svh */
// fixed constants of the csi-2 receiver: lane count, sync pattern, skew depth, long packet limit
`ifndef CSI_RX_SETTINGS_SVH
`define CSI_RX_SETTINGS_SVH

// two data lanes, lane 0 in the low byte of every bus
`define CSI_RX_LANES 2

// leader byte that follows the hs-zero period on each lane
`define CSI_RX_SYNC_BYTE 8'hB8

// deepest tap in the word aligner delay line, in byte clocks
`define CSI_RX_MAX_SKEW 2

// data types at or above this value carry a payload
`define CSI_RX_LONG_MIN 6'h10

`endif

/* flist.f */
+incdir+common
common/csi_rx_pkg.sv
verilog/csi_rx_byte_align.sv
word_align/csi_rx_word_align.sv
verilog/csi_rx_packet_handler.sv
verilog/csi_rx_top.sv
test/csi_rx_assert.sv
test/csi_rx_tb.sv

/* test/csi_rx_assert.sv */
// concurrent checks on header, payload and packet end of the receiver, bound into csi_rx_top
`timescale 1ns/1ns

module csi_rx_assert (
   input logic                   byte_clock,
   input logic                   reset,
   input logic                   enable,
   input logic                   header_valid,
   input logic                   packet_done,   // handler pulse, internal to the top
   input csi_rx_pkg::lane_byte_t lane0,
   input csi_rx_pkg::lane_byte_t lane1,
   input csi_rx_pkg::word_t      payload
);

   logic sync_seen;   // some lane has locked since reset
   logic in_gap;      // between packet_done and the next header

   always_ff @(posedge byte_clock) begin
      if (reset) begin
         sync_seen <= 1'b0;
         in_gap    <= 1'b0;
      end else if (enable) begin
         if (lane0.valid || lane1.valid) sync_seen <= 1'b1;
         if (packet_done) begin
            in_gap <= 1'b1;   // short packets end on their header cycle
         end else if (header_valid) begin
            in_gap <= 1'b0;
         end
      end
   end

   no_output_before_sync: assert property (@(posedge byte_clock) disable iff (reset)
      !sync_seen |-> (!header_valid && !payload.valid))
      else $error("header or payload seen before any sync byte");

   header_single_cycle: assert property (@(posedge byte_clock) disable iff (reset)
      (header_valid && enable) |=> !header_valid)
      else $error("header_valid held longer than one cycle");

   no_payload_in_gap: assert property (@(posedge byte_clock) disable iff (reset)
      in_gap |-> !payload.valid)
      else $error("payload word between packet end and next header");

endmodule

bind csi_rx_top csi_rx_assert assert_checks (
   .byte_clock   (byte_clock),
   .reset        (reset),
   .enable       (enable),
   .header_valid (header_valid),
   .packet_done  (packet_done),
   .lane0        (lane0),
   .lane1        (lane1),
   .payload      (payload)
);

/* test/csi_rx_stim.txt */
# raw_bytes (lane 1 high byte) enable tag value repeat, all hex but repeat
# tag 0 none, 1 expected header {vc, data_type, word_count}, 2 expected payload word
0000 1 0 000000 4
B8B8 1 1 2A0004 1
042A 1 0 000000 1
3F00 1 0 000000 1
2211 1 2 002211 1
2211 0 0 000000 3
4433 1 2 004433 1
0000 1 0 000000 10
00B8 1 1 2A0004 1
B82A 1 0 000000 1
0400 1 0 000000 1
3F11 1 2 002211 1
2233 1 2 004433 1
4400 1 0 000000 1
0000 1 0 000000 10
00B8 1 1 2A0004 1
002A 1 0 000000 1
B800 1 0 000000 1
0411 1 2 002211 1
3F33 1 2 004433 1
2200 1 0 000000 1
4400 1 0 000000 1
0000 1 0 000000 10
C000 1 0 000000 1
2557 1 1 2A0004 1
F805 1 0 000000 1
1120 1 2 002211 1
2162 1 2 004433 1
0206 1 0 000000 1
0000 1 0 000000 10
B8B8 1 1 000001 1
0100 1 0 000000 1
0700 1 0 000000 1
0000 1 0 000000 8
B8B8 1 1 010001 1
0101 1 0 000000 1
1A00 1 0 000000 1
0000 1 0 000000 8
00B8 1 0 000000 1
002A 1 0 000000 1
0000 1 0 000000 14
B8B8 1 1 6A0004 1
046A 1 0 000000 1
3F00 1 0 000000 1
2211 1 2 002211 1
4433 1 2 004433 1
0000 1 0 000000 16

/* test/csi_rx_tb.sv */
// testbench for csi_rx_top with clock, reset, stimulus file, header and payload compares and watchdog
`timescale 1ns/1ns

module csi_rx_tb;

   logic                byte_clock;
   logic                reset;
   logic                enable;
   logic [15:0]         raw_bytes;
   csi_rx_pkg::header_t header;
   logic                header_valid;
   csi_rx_pkg::word_t   payload;

   logic [15:0]         raw_q [$];         // one entry per clock with repeats expanded
   logic                en_q [$];
   csi_rx_pkg::header_t exp_headers [$];
   logic [15:0]         exp_words [$];
   logic                updated;           // enable as seen by the DUT at the last edge
   logic                loaded;
   int                  cycles;

   csi_rx_top UUT (
      .byte_clock   (byte_clock),
      .reset        (reset),
      .enable       (enable),
      .raw_bytes    (raw_bytes),
      .header       (header),
      .header_valid (header_valid),
      .payload      (payload)
   );

   always #4 byte_clock = ~byte_clock;   // 8 ns period

   task automatic end_in_failure();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_header(input csi_rx_pkg::header_t got, input csi_rx_pkg::header_t exp);
      if (got !== exp) begin
         $display("FAIL time %0t header expected %h got %h", $time, exp, got);
         end_in_failure();
      end
   endtask

   task automatic check_payload(input csi_rx_pkg::word_t got, input csi_rx_pkg::word_t exp);
      if (got !== exp) begin
         $display("FAIL time %0t payload expected %h got %h", $time, exp, got);
         end_in_failure();
      end
   endtask

   always @(posedge byte_clock) updated <= enable;

   // outputs only move on enabled edges, so sample them mid cycle
   always @(negedge byte_clock) begin : compare_outputs
      csi_rx_pkg::word_t exp_word;
      if (!reset && updated) begin
         if (header_valid) begin
            if (exp_headers.size() == 0) begin
               $display("unexpected header %h at time %0t", header, $time);
               end_in_failure();
            end else begin
               check_header(header, exp_headers.pop_front());
            end
         end
         if (payload.valid) begin
            if (exp_words.size() == 0) begin
               $display("unexpected payload word %h at time %0t", payload.data, $time);
               end_in_failure();
            end else begin
               exp_word = '{data: exp_words.pop_front(), valid: 1'b1};
               check_payload(payload, exp_word);
            end
         end
      end
   end

   initial begin : run_test
      int          fd;
      int          n;
      int          en;
      int          tag;
      int          count;
      string       line;
      logic [15:0] raw;
      logic [23:0] value;
      byte_clock = 1'b0;
      reset      = 1'b1;
      enable     = 1'b1;
      raw_bytes  = '0;
      updated    = 1'b0;
      fd = $fopen("test/csi_rx_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file test/csi_rx_stim.txt");
         end_in_failure();
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %d", raw, en, tag, value, count);
            if (n != 5) begin
               $display("badly formed stimulus line: %s", line);
               end_in_failure();
            end
            if (tag == 1) exp_headers.push_back(value);
            if (tag == 2) exp_words.push_back(value[15:0]);
            repeat (count) begin
               raw_q.push_back(raw);
               en_q.push_back(en[0]);
            end
         end
      end
      $fclose(fd);
      cycles = raw_q.size();
      loaded = 1'b1;   // starts the watchdog
      repeat (5) @(posedge byte_clock);
      reset <= 1'b0;
      for (int i = 0; i < cycles; i++) begin
         @(posedge byte_clock);
         raw_bytes <= raw_q[i];
         enable    <= en_q[i];
      end
      // wait for the last expected events to leave the pipeline, bounded
      for (int i = 0; i < 12; i++) begin
         if (exp_headers.size() == 0 && exp_words.size() == 0) break;
         @(posedge byte_clock);
      end
      @(negedge byte_clock);
      if (exp_headers.size() == 0 && exp_words.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("expected events were missing: %0d headers and %0d payload words",
                  exp_headers.size(), exp_words.size());
         end_in_failure();
      end
   end

   initial begin : watchdog
      wait (loaded === 1'b1);
      #(8 * cycles + 200);
      $display("timeout, the run did not finish within %0d ns", 8 * cycles + 200);
      end_in_failure();
   end

endmodule

/* verilog/csi_rx_byte_align.sv */
// per-lane byte aligner with sync byte search over eight bit offsets and offset lock
`timescale 1ns/1ns
`include "csi_rx_settings.svh"

module csi_rx_byte_align (
   input  logic                   byte_clock,
   input  logic                   reset,         // sync, active high
   input  logic                   enable,        // low freezes every register
   input  logic                   packet_done,   // unlock and search again
   input  logic [7:0]             raw_byte,      // deserialized byte with unknown bit boundary
   output csi_rx_pkg::lane_byte_t lane
);

   logic [7:0]  curr_byte;      // newest raw byte
   logic [7:0]  last_byte;      // the one before it
   logic [15:0] joined;         // window of 16 bits to slide over
   logic [2:0]  offset;         // locked bit offset
   logic        locked;
   logic        found;          // sync pattern somewhere in the window
   logic [2:0]  found_offset;
   logic [7:0]  byte_q;
   logic        valid_q;

   // bits arrive lsb first so the older byte sits in the low half
   assign joined = {curr_byte, last_byte};

   // eight-way compare
   always_comb begin
      found        = 1'b0;
      found_offset = 3'd0;
      for (int k = 7; k >= 0; k--) begin   // walk down so lowest offset is the last hit
         if (joined[k +: 8] == `CSI_RX_SYNC_BYTE) begin
            found        = 1'b1;
            found_offset = 3'(k);
         end
      end
   end

   // raw byte pipe and shifted output byte
   always_ff @(posedge byte_clock) begin
      if (enable) begin
         curr_byte <= raw_byte;
         last_byte <= curr_byte;
         byte_q    <= joined[offset +: 8];   // uses the new offset from the byte after sync
      end
   end

   // lock control
   always_ff @(posedge byte_clock) begin
      if (reset) begin
         locked  <= 1'b0;
         offset  <= 3'd0;
         valid_q <= 1'b0;
      end else if (enable) begin
         valid_q <= locked;   // follows lock one cycle late, so it drops a cycle after packet_done
         if (packet_done) begin
            locked <= 1'b0;
         end else if (!locked && found) begin
            locked <= 1'b1;          // hold this offset for the rest of the packet
            offset <= found_offset;
         end
      end
   end

   assign lane = '{data: byte_q, valid: valid_q};

endmodule

/* verilog/csi_rx_packet_handler.sv */
// packet handler: header decode, payload forwarding, packet end and sync request
`timescale 1ns/1ns
`include "csi_rx_settings.svh"

module csi_rx_packet_handler (
   input  logic                byte_clock,
   input  logic                reset,
   input  logic                enable,
   input  csi_rx_pkg::word_t   aligned,         // deskewed word from the word aligner
   output logic                wait_for_sync,   // lets the word aligner lock
   output logic                packet_done,     // one cycle after the last word
   output csi_rx_pkg::header_t header,
   output logic                header_valid,
   output csi_rx_pkg::word_t   payload
);

   csi_rx_pkg::packet_state_e state;
   logic [7:0]  data_id;        // vc and data type from header word 0
   logic [7:0]  count_lo;       // word_count low byte
   logic [15:0] word_count;     // full count once header word 1 is on the bus
   logic [14:0] words_left;     // payload words still to forward
   logic        is_long;
   logic        take_hdr0;
   logic        take_hdr1;
   logic [15:0] payload_data;
   logic        payload_valid;

   assign word_count    = {aligned.data[7:0], count_lo};
   assign is_long       = (data_id[5:0] >= `CSI_RX_LONG_MIN);
   assign wait_for_sync = (state == csi_rx_pkg::idle);
   // aligner still shows the word after the crc while packet_done is high
   assign take_hdr0 = (state == csi_rx_pkg::idle) && aligned.valid && !packet_done;
   assign take_hdr1 = (state == csi_rx_pkg::header_hi) && aligned.valid;

   always_ff @(posedge byte_clock) begin
      if (reset) begin
         state         <= csi_rx_pkg::idle;
         words_left    <= '0;
         header_valid  <= 1'b0;
         packet_done   <= 1'b0;
         payload_valid <= 1'b0;
      end else if (enable) begin
         header_valid  <= 1'b0;   // pulses by default
         packet_done   <= 1'b0;
         payload_valid <= 1'b0;
         case (state)
            csi_rx_pkg::idle: begin
               if (take_hdr0) state <= csi_rx_pkg::header_hi;
            end
            csi_rx_pkg::header_hi: begin
               if (take_hdr1) begin
                  header_valid <= 1'b1;
                  if (!is_long) begin
                     packet_done <= 1'b1;   // short packet ends at header word 1
                     state       <= csi_rx_pkg::idle;
                  end else if (word_count[15:1] == '0) begin
                     state <= csi_rx_pkg::checksum;   // empty long packet
                  end else begin
                     words_left <= word_count[15:1];  // two bytes per word
                     state      <= csi_rx_pkg::payload;
                  end
               end
            end
            csi_rx_pkg::payload: begin
               if (aligned.valid) begin
                  payload_valid <= 1'b1;
                  words_left    <= words_left - 15'd1;
                  if (words_left == 15'd1) state <= csi_rx_pkg::checksum;
               end
            end
            csi_rx_pkg::checksum: begin
               if (aligned.valid) begin
                  packet_done <= 1'b1;   // crc consumed, not checked
                  state       <= csi_rx_pkg::idle;
               end
            end
            default: state <= csi_rx_pkg::idle;
         endcase
      end
   end

   // header fields and payload data
   always_ff @(posedge byte_clock) begin
      if (enable) begin
         payload_data <= aligned.data;
         if (take_hdr0) begin
            data_id  <= aligned.data[7:0];
            count_lo <= aligned.data[15:8];
         end
         if (take_hdr1) begin
            header <= '{virtual_channel: data_id[7:6],
                        data_type:       data_id[5:0],
                        word_count:      word_count};   // ecc byte in data[15:8] dropped
         end
      end
   end

   assign payload = '{data: payload_data, valid: payload_valid};

endmodule

/* verilog/csi_rx_top.sv */
// receiver top: two byte aligners, word aligner and packet handler
`timescale 1ns/1ns

module csi_rx_top (
   input  logic                byte_clock,
   input  logic                reset,
   input  logic                enable,
   input  logic [15:0]         raw_bytes,      // lane 1 high byte, lane 0 low byte
   output csi_rx_pkg::header_t header,
   output logic                header_valid,
   output csi_rx_pkg::word_t   payload
);

   csi_rx_pkg::lane_byte_t lane0;
   csi_rx_pkg::lane_byte_t lane1;
   csi_rx_pkg::word_t      aligned;
   logic                   packet_done;       // handler to word aligner
   logic                   packet_done_out;   // word aligner to both byte aligners
   logic                   wait_for_sync;

   csi_rx_byte_align lane0_align (
      .byte_clock  (byte_clock),
      .reset       (reset),
      .enable      (enable),
      .packet_done (packet_done_out),
      .raw_byte    (raw_bytes[7:0]),
      .lane        (lane0)
   );

   csi_rx_byte_align lane1_align (
      .byte_clock  (byte_clock),
      .reset       (reset),
      .enable      (enable),
      .packet_done (packet_done_out),
      .raw_byte    (raw_bytes[15:8]),
      .lane        (lane1)
   );

   csi_rx_word_align word_align (
      .byte_clock      (byte_clock),
      .reset           (reset),
      .enable          (enable),
      .packet_done     (packet_done),
      .wait_for_sync   (wait_for_sync),
      .word_in         ({lane1.data, lane0.data}),
      .valid_in        ({lane1.valid, lane0.valid}),
      .packet_done_out (packet_done_out),
      .aligned         (aligned)
   );

   csi_rx_packet_handler packet_handler (
      .byte_clock    (byte_clock),
      .reset         (reset),
      .enable        (enable),
      .aligned       (aligned),
      .wait_for_sync (wait_for_sync),
      .packet_done   (packet_done),
      .header        (header),
      .header_valid  (header_valid),
      .payload       (payload)
   );

endmodule

/* word_align/csi_rx_word_align.sv */
// word aligner: lane deskew by tap selection, failed start detection, packet_done_out
`timescale 1ns/1ns
`include "csi_rx_settings.svh"

module csi_rx_word_align (
   input  logic              byte_clock,
   input  logic              reset,
   input  logic              enable,
   input  logic              packet_done,       // from packet handler
   input  logic              wait_for_sync,     // handler idle, ok to lock
   input  logic [15:0]       word_in,           // bytes from both byte aligners
   input  logic [1:0]        valid_in,          // lane valids, bit 0 is lane 0
   output logic              packet_done_out,   // restarts the byte aligners
   output csi_rx_pkg::word_t aligned
);

   logic [8*`CSI_RX_LANES-1:0] word_dly  [0:`CSI_RX_MAX_SKEW];   // stage 0 is newest
   logic [`CSI_RX_LANES-1:0]   valid_dly [0:`CSI_RX_MAX_SKEW];
   logic [1:0]                 taps      [`CSI_RX_LANES];         // latched per lane
   logic [1:0]                 next_taps [`CSI_RX_LANES];         // from valid age
   logic [1:0]                 sel_taps  [`CSI_RX_LANES];
   logic [`CSI_RX_LANES-1:0]   lane_full;      // lane valid through the whole delay line
   logic                       locked;
   logic                       next_valid;
   logic                       lock_now;
   logic                       invalid_start;
   logic [8*`CSI_RX_LANES-1:0] aligned_word;
   logic [8*`CSI_RX_LANES-1:0] aligned_data;
   logic                       aligned_valid;

   // tap per lane is the age of its valid, oldest stage wins
   always_comb begin
      for (int i = 0; i < `CSI_RX_LANES; i++) begin
         next_taps[i] = 2'd0;
         lane_full[i] = 1'b1;
         for (int d = 0; d <= `CSI_RX_MAX_SKEW; d++) begin
            if (valid_dly[d][i]) begin
               next_taps[i] = 2'(d);
            end else begin
               lane_full[i] = 1'b0;
            end
         end
      end
   end

   // all lanes valid and the latest one just started, stale valids after a packet never lock
   assign next_valid    = (&valid_dly[0]) & (|(valid_dly[0] & ~valid_dly[1]));
   assign lock_now      = next_valid & ~locked & wait_for_sync;
   assign invalid_start = ~(&valid_dly[0]) & (|lane_full);   // one lane ran ahead too far

   // on the lock cycle the fresh taps already pick header word 0
   always_comb begin
      for (int i = 0; i < `CSI_RX_LANES; i++) begin
         sel_taps[i] = lock_now ? next_taps[i] : taps[i];
         aligned_word[8*i +: 8] = word_dly[sel_taps[i]][8*i +: 8];
      end
   end

   // byte delay line and output word, payload only
   always_ff @(posedge byte_clock) begin
      if (enable) begin
         word_dly[0]  <= word_in;
         for (int d = 1; d <= `CSI_RX_MAX_SKEW; d++) begin
            word_dly[d] <= word_dly[d-1];
         end
         aligned_data <= aligned_word;
      end
   end

   always_ff @(posedge byte_clock) begin
      if (reset) begin
         valid_dly     <= '{default: '0};
         taps          <= '{default: 2'd0};
         locked        <= 1'b0;
         aligned_valid <= 1'b0;
      end else if (enable) begin
         valid_dly[0] <= valid_in;
         for (int d = 1; d <= `CSI_RX_MAX_SKEW; d++) begin
            valid_dly[d] <= valid_dly[d-1];
         end
         aligned_valid <= lock_now | (locked & ~packet_done);
         if (lock_now) begin
            locked <= 1'b1;
            taps   <= next_taps;   // keep skew fixed until the packet ends
         end else if (packet_done) begin
            locked <= 1'b0;
         end
      end
   end

   assign aligned         = '{data: aligned_data, valid: aligned_valid};
   assign packet_done_out = packet_done | invalid_start;   // either ends the byte aligner lock

endmodule
